// File: hdl/sramPkg.sv
/*
 Shared widths and payload types for the two-client SRAM controller.
 Sized for an 8-bit asynchronous SRAM with 19 address bits.
 FIFO_DEPTH must be a power of two, because the FIFO pointers wrap naturally.
 PORT_LAT must be at least 2 so that the arbiter's client delay line has two or more stages.
*/
`default_nettype none

package sramPkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int ADDR_W      = 19;
	localparam int DQ_W        = 8;
	localparam int NUM_CLIENTS = 2;
	localparam int CLIENT_W    = 1;
	localparam int FIFO_DEPTH  = 4;

	// Derived FIFO widths
	localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

	// Edges from command strobe to read-valid in the port unit
	localparam int PORT_LAT    = 2;

	// ------------------------------
	// Payload types
	// ------------------------------
	// Client command, also the FIFO payload
	typedef struct packed {
		logic              write;   // 1 write, 0 read
		logic [ADDR_W-1:0] addr;
		logic [DQ_W-1:0]   data;    // Ignored on reads
	} sramCmd_t;

	// Chip pins, strobes active low
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DQ_W-1:0]   dq;
		logic              ceN;
		logic              oeN;
		logic              weN;
	} sramPins_t;

	// Read return, tagged with the requesting client
	typedef struct packed {
		logic [CLIENT_W-1:0] client;
		logic [DQ_W-1:0]     data;
	} sramRead_t;

endpackage

`default_nettype wire

// File: hdl/sramCmdFifo.sv
/*
 Show-ahead synchronous FIFO for one client's commands.
 The head is on dout combinationally whenever empty is low.
 Depth comes from FIFO_DEPTH, which must be a power of two.
 A push while full or a pop while empty is a protocol error.
 Both are flagged by assertions and ignored by the logic.
*/
`default_nettype none

module sramCmdFifo #(
	parameter type payload_t = sramPkg::sramCmd_t
) (
	input  logic     iCLK,
	input  logic     iRST,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     empty,
	output logic     full
);

	import sramPkg::*;

	// ------------------------------
	// Storage and pointers
	// ------------------------------
	payload_t               mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0]  wrPtr;
	logic [FIFO_PTR_W-1:0]  rdPtr;
	logic [FIFO_CNT_W-1:0]  count;
	logic                   doPush;
	logic                   doPop;

	// Illegal requests are dropped
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	// Entry array, no reset
	always_ff @(posedge iCLK)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	// Pointers wrap at the power-of-two depth
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

	// ------------------------------
	// Status and head
	// ------------------------------
	assign empty = (count == '0);
	assign full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign dout  = mem[rdPtr];

	// Client must honor reqFull
	assert property (@(posedge iCLK) disable iff (iRST) !(push && full))
		else $error("sramCmdFifo: push while full");

	// Arbiter must only pop a non-empty FIFO
	assert property (@(posedge iCLK) disable iff (iRST) !(pop && empty))
		else $error("sramCmdFifo: pop while empty");

endmodule

`default_nettype wire

// File: hdl/sramArbiter.sv
/*
 Round-robin arbiter over the command FIFO heads.
 Grants in the same cycle that a head is non-empty, so pop, grantId and cmdValid are
 combinational from empty and the pointer.
 At most one command is granted per cycle.
 rdClient is grantId delayed by PORT_LAT edges, which lines it up with the port unit's rdValid.
*/
`default_nettype none

module sramArbiter (
	input  logic                             iCLK,
	input  logic                             iRST,
	input  logic [sramPkg::NUM_CLIENTS-1:0]  empty,
	output logic [sramPkg::NUM_CLIENTS-1:0]  pop,
	output logic                             cmdValid,
	output logic [sramPkg::CLIENT_W-1:0]     grantId,
	output logic [sramPkg::CLIENT_W-1:0]     rdClient
);

	import sramPkg::*;

	logic [CLIENT_W-1:0]               rrPtr;      // client with top priority
	logic [CLIENT_W-1:0]               pick;
	logic                              anyReq;
	logic [PORT_LAT-1:0][CLIENT_W-1:0] clientDly;

	// ------------------------------
	// Client selection
	// ------------------------------
	assign anyReq = ~&empty;

	// Walk from farthest to nearest
	// Last non-empty hit is the one closest to rrPtr
	always_comb
	begin
		int idx;
		pick = rrPtr;
		for (int i = NUM_CLIENTS - 1; i >= 0; i--)
		begin
			idx = (int'(rrPtr) + i) % NUM_CLIENTS;
			if (!empty[idx])
				pick = CLIENT_W'(idx);
		end
	end

	assign pop      = anyReq ? (NUM_CLIENTS'(1) << pick) : '0;
	assign cmdValid = anyReq;
	assign grantId  = pick;

	// Pointer moves past the winner, so busy clients alternate
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rrPtr <= '0;
		else if (anyReq)
		begin
			if (pick == CLIENT_W'(NUM_CLIENTS - 1))
				rrPtr <= '0;
			else
				rrPtr <= pick + 1'b1;
		end
	end

	// ------------------------------
	// Read steering
	// ------------------------------
	// Same depth as the port unit pipeline
	// Tag is payload only, rdValid qualifies it
	always_ff @(posedge iCLK)
	begin
		clientDly <= {clientDly[PORT_LAT-2:0], grantId};
	end

	assign rdClient = clientDly[PORT_LAT-1];

	// One pop per cycle
	assert property (@(posedge iCLK) disable iff (iRST) $onehot0(pop))
		else $error("sramArbiter: pop not one-hot");

	// Busy pair alternates between grants
	assert property (@(posedge iCLK) disable iff (iRST)
		(empty == '0) ##1 (empty == '0) |-> (grantId != $past(grantId)))
		else $error("sramArbiter: round-robin did not alternate");

endmodule

`default_nettype wire

// File: hdl/sramPortUnit.sv
/*
 Pin driver for an asynchronous SRAM at 50 MHz or below.
 Address, data and strobes are registered, so the chip sees a full clock of setup.
 DQ is split into dq out and dqIn, and the tri-state is resolved outside.
 A strobe taken at edge M drives the pins in the following cycle.
 For a read, dqIn is captured at M+1 and rdValid is high in the cycle after that.
 LB and UB are not driven. An 8-bit part has them tied low on the board.
*/
`default_nettype none

module sramPortUnit (
	input  logic                      iCLK,
	input  logic                      iRST,
	input  logic                      cmdValid,
	input  sramPkg::sramCmd_t         cmd,
	output sramPkg::sramPins_t        pins,
	input  logic [sramPkg::DQ_W-1:0]  dqIn,
	output logic [sramPkg::DQ_W-1:0]  rdData,
	output logic                      rdValid
);

	import sramPkg::*;

	logic readCycle;

	// ------------------------------
	// Pin register
	// ------------------------------
	// Chip truth table
	//   CE high      deselected
	//   CE, OE low   read, chip drives DQ
	//   CE, WE low   write, chip takes DQ
	always_ff @(posedge iCLK)
	begin
		// Address and data follow cmd every cycle
		pins.addr <= cmd.addr;
		pins.dq   <= cmd.data;

		if (iRST)
		begin
			pins.ceN <= 1'b1;
			pins.oeN <= 1'b1;
			pins.weN <= 1'b1;
		end
		else if (cmdValid)
		begin
			pins.ceN <= 1'b0;
			pins.oeN <= cmd.write;
			pins.weN <= !cmd.write;
		end
		else
		begin
			// Idle, chip deselected with all strobes high
			pins.ceN <= 1'b1;
			pins.oeN <= 1'b1;
			pins.weN <= 1'b1;
		end
	end

	// ------------------------------
	// Read capture
	// ------------------------------
	assign readCycle = !pins.ceN && !pins.oeN;

	// Data held between reads
	always_ff @(posedge iCLK)
	begin
		if (readCycle)
			rdData <= dqIn;
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			rdValid <= 1'b0;
		else
			rdValid <= readCycle;
	end

	// Selected chip is either reading or writing
	assert property (@(posedge iCLK) disable iff (iRST)
		!pins.ceN |-> (pins.oeN ^ pins.weN))
		else $error("sramPortUnit: CE low without exactly one of OE, WE");

	// Read strobe returns data exactly PORT_LAT edges later
	assert property (@(posedge iCLK) disable iff (iRST)
		(cmdValid && !cmd.write) |-> ##PORT_LAT rdValid)
		else $error("sramPortUnit: read without rdValid at fixed latency");

endmodule

`default_nettype wire

// File: hdl/sramSubsystemTop.sv
/*
 Two-client SRAM controller. Each client has a command FIFO, a round-robin arbiter
 serves the FIFOs, and a registered port unit drives the pins.
 Clients strobe reqValid with req and must hold off while reqFull is high.
 rdValid is shared by both clients, and rd.client tells whose data it is.
 rdValid is high at the earliest in the cycle after the third rising edge, counted
 from the edge that samples the push. Arbitration and queueing add to that.
*/
`default_nettype none

module sramSubsystemTop (
	input  logic                             iCLK,
	input  logic                             iRST,
	input  logic [sramPkg::NUM_CLIENTS-1:0]  reqValid,
	input  sramPkg::sramCmd_t                req [sramPkg::NUM_CLIENTS],
	output logic [sramPkg::NUM_CLIENTS-1:0]  reqFull,
	output sramPkg::sramPins_t               pins,
	input  logic [sramPkg::DQ_W-1:0]         dqIn,
	output logic                             rdValid,
	output sramPkg::sramRead_t               rd
);

	import sramPkg::*;

	sramCmd_t               fifoHead [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] fifoEmpty;
	logic [NUM_CLIENTS-1:0] fifoPop;
	logic                   cmdValid;
	sramCmd_t               cmd;
	logic [CLIENT_W-1:0]    grantId;
	logic [CLIENT_W-1:0]    rdClient;
	logic [DQ_W-1:0]        rdData;

	// ------------------------------
	// Per-client command queues
	// ------------------------------
	for (genvar gi = 0; gi < NUM_CLIENTS; gi++)
	begin : gClient
		sramCmdFifo #(
			.payload_t (sramCmd_t)
		) uFifo (
			.iCLK  (iCLK),
			.iRST  (iRST),
			.push  (reqValid[gi]),
			.din   (req[gi]),
			.pop   (fifoPop[gi]),
			.dout  (fifoHead[gi]),
			.empty (fifoEmpty[gi]),
			.full  (reqFull[gi])
		);
	end

	// ------------------------------
	// Arbitration and pins
	// ------------------------------
	sramArbiter uArbiter (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.empty    (fifoEmpty),
		.pop      (fifoPop),
		.cmdValid (cmdValid),
		.grantId  (grantId),
		.rdClient (rdClient)
	);

	// Head of the winning queue
	assign cmd = fifoHead[grantId];

	sramPortUnit uPortUnit (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.cmdValid (cmdValid),
		.cmd      (cmd),
		.pins     (pins),
		.dqIn     (dqIn),
		.rdData   (rdData),
		.rdValid  (rdValid)
	);

	// Tag read data with its requester
	assign rd = '{client: rdClient, data: rdData};

endmodule

`default_nettype wire

// File: verification/sramModel.sv
/*
 Behavioral asynchronous SRAM, 8 bits wide, for simulation only.
 Writes while CE and WE are low, and drives dqOut while CE and OE are low.
 No access time is modeled, so read data appears in the same time step.
 Every word starts with a fill value derived from its whole address.
*/
`default_nettype none

module sramModel (
	input  sramPkg::sramPins_t       pins,
	output logic [sramPkg::DQ_W-1:0] dqOut
);

	import sramPkg::*;

	localparam int WORDS = 1 << ADDR_W;

	logic [DQ_W-1:0] mem [WORDS];

	// Fold all address bits into one byte
	function automatic logic [DQ_W-1:0] fillValue(logic [ADDR_W-1:0] addr);
		return addr[7:0] ^ addr[15:8] ^ DQ_W'(addr[ADDR_W-1:16]);
	endfunction

	initial
	begin
		for (int a = 0; a < WORDS; a++)
			mem[a] = fillValue(ADDR_W'(a));
	end

	// Level-sensitive write, as on the real part
	always @(pins)
	begin
		if (!pins.ceN && !pins.weN)
			mem[pins.addr] = pins.dq;
	end

	// Bus floats unless the chip is reading
	assign dqOut = (!pins.ceN && !pins.oeN && pins.weN) ? mem[pins.addr] : 'z;

endmodule

`default_nettype wire

// File: verification/sramTb.sv
/*
 Trace-driven testbench for the two-client SRAM controller.
 Trace steps are applied on the falling edge, where outputs are also sampled.
 A read push carries the value the read must return.
 Unwritten words read back the model's address-derived fill.
*/
`default_nettype none

module sramTb;

	import sramPkg::*;

	localparam int CYCLE_LIMIT = 200;   // per wait loop

	logic                   iCLK;
	logic                   iRST;
	logic [NUM_CLIENTS-1:0] reqValid;
	sramCmd_t               req [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] reqFull;
	sramPins_t              pins;
	logic [DQ_W-1:0]        dqIn;
	logic                   rdValid;
	sramRead_t              rd;

	// Pushes waiting for their cycle
	logic [NUM_CLIENTS-1:0] pendValid;
	sramCmd_t               pendCmd [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] sawFull;

	// Expected returns per client, push order
	logic [DQ_W-1:0]   expRd0 [$];
	logic [DQ_W-1:0]   expRd1 [$];
	logic [ADDR_W-1:0] expAddr [$];
	int                errors;
	int                checks;

	sramSubsystemTop dut (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.reqValid (reqValid),
		.req      (req),
		.reqFull  (reqFull),
		.pins     (pins),
		.dqIn     (dqIn),
		.rdValid  (rdValid),
		.rd       (rd)
	);

	sramModel uSram (
		.pins  (pins),
		.dqOut (dqIn)
	);

	initial iCLK = 1'b0;
	always #20 iCLK = ~iCLK;

	// ------------------------------
	// Checks
	// ------------------------------
	task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] gotVal);
		$display("Fail at %0t: %s expected %0h, got %0h", $time, name, expVal, gotVal);
		errors++;
	endtask

	// Deselected chip, all strobes high
	task automatic checkIdle();
		checks++;
		if (pins.ceN !== 1'b1 || pins.oeN !== 1'b1 || pins.weN !== 1'b1)
			reportMismatch("pins.ceN,oeN,weN", 3'b111, {pins.ceN, pins.oeN, pins.weN});
	endtask

	task automatic matchReturn();
		logic [DQ_W-1:0] expData;
		checks++;
		if (rd.client == 1'b0 && expRd0.size() != 0)
			expData = expRd0.pop_front();
		else if (rd.client == 1'b1 && expRd1.size() != 0)
			expData = expRd1.pop_front();
		else
		begin
			$display("Read data at %0t for client %0d, which has no read outstanding",
				$time, rd.client);
			errors++;
			return;
		end
		if (rd.data !== expData)
			reportMismatch("rd.data", expData, rd.data);
	endtask

	task automatic matchAddress();
		logic [ADDR_W-1:0] expA;
		checks++;
		expA = expAddr.pop_front();
		if (pins.addr !== expA)
			reportMismatch("pins.addr", expA, pins.addr);
	endtask

	// Every read return, both clients
	always @(negedge iCLK)
	begin
		if (!iRST && rdValid)
			matchReturn();
	end

	// Pin address order, only while expected
	always @(negedge iCLK)
	begin
		if (!iRST && !pins.ceN && expAddr.size() != 0)
			matchAddress();
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic expectRead(int client, logic [DQ_W-1:0] data);
		if (client == 0)
			expRd0.push_back(data);
		else
			expRd1.push_back(data);
	endtask

	// One cycle per pass, held pushes retried while full
	task automatic applyPushes();
		int waitCycles;
		waitCycles = 0;
		while (pendValid != '0 && waitCycles < CYCLE_LIMIT)
		begin
			for (int c = 0; c < NUM_CLIENTS; c++)
			begin
				if (pendValid[c] && !reqFull[c])
				begin
					reqValid[c]  = 1'b1;
					req[c]       = pendCmd[c];
					pendValid[c] = 1'b0;
				end
			end
			@(posedge iCLK);
			@(negedge iCLK);
			reqValid = '0;
			sawFull  = sawFull | reqFull;
			waitCycles++;
		end
		if (pendValid != '0)
		begin
			$display("Timeout at %0t: a client FIFO never left full", $time);
			errors++;
			pendValid = '0;
		end
	endtask

	task automatic queuePush(int client, logic write, logic [ADDR_W-1:0] addr,
		logic [DQ_W-1:0] data);
		pendValid[client] = 1'b1;
		pendCmd[client]   = '{write: write, addr: addr, data: write ? data : '0};
		if (!write)
			expectRead(client, data);
	endtask

	// Edges from push to rdValid, lone client
	task automatic measureLatency(int client, logic [ADDR_W-1:0] addr, logic [DQ_W-1:0] data);
		int edges;
		queuePush(client, 1'b0, addr, data);
		applyPushes();
		// Edge that took the push is the first one
		edges = 1;
		while (!rdValid && edges < 10)
		begin
			@(posedge iCLK);
			@(negedge iCLK);
			edges++;
		end
		checks++;
		if (!rdValid)
		begin
			$display("Timeout at %0t: no rdValid after a read push", $time);
			errors++;
		end
		else if (edges != 3)
			reportMismatch("read latency", 3, edges);
	endtask

	// Wait out all reads, then expect an idle chip
	task automatic drainReads();
		int waitCycles;
		waitCycles = 0;
		while ((expRd0.size() != 0 || expRd1.size() != 0) && waitCycles < CYCLE_LIMIT)
		begin
			@(posedge iCLK);
			@(negedge iCLK);
			waitCycles++;
		end
		if (expRd0.size() != 0 || expRd1.size() != 0)
		begin
			$display("Timeout at %0t: reads still outstanding", $time);
			errors++;
			expRd0.delete();
			expRd1.delete();
		end
		repeat (3)
		begin
			@(posedge iCLK);
			@(negedge iCLK);
		end
		checkIdle();
	endtask

	task automatic runStep(byte op, logic [31:0] f1, logic [31:0] f2, logic [31:0] f3,
		logic [31:0] f4);
		case (op)
			"P", "M":
			begin
				queuePush(f1, f2[0], f3[ADDR_W-1:0], f4[DQ_W-1:0]);
				// M shares its cycle with the next line
				if (op == "P")
					applyPushes();
			end
			"A": expAddr.push_back(f1[ADDR_W-1:0]);
			"L": measureLatency(f1, f2[ADDR_W-1:0], f3[DQ_W-1:0]);
			"D": drainReads();
			"F":
			begin
				checks++;
				if (!(sawFull[f1] || reqFull[f1]))
				begin
					$display("Client %0d never raised reqFull before %0t", f1, $time);
					errors++;
				end
				sawFull[f1] = 1'b0;
			end
			default:
			begin
				$display("Unknown trace step %c", op);
				errors++;
			end
		endcase
	endtask

	initial
	begin
		int          fd;
		int          code;
		string       line;
		byte         op;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		errors    = 0;
		checks    = 0;
		iRST      = 1'b1;
		reqValid  = '0;
		pendValid = '0;
		sawFull   = '0;
		for (int c = 0; c < NUM_CLIENTS; c++)
		begin
			req[c]     = '0;
			pendCmd[c] = '0;
		end

		// Strobes stay high through reset
		repeat (5)
		begin
			@(negedge iCLK);
			checkIdle();
		end
		iRST = 1'b0;

		fd = $fopen("verification/sramTrace.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the trace file");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				// Skip blanks and comment lines
				if (code > 1 && line.getc(0) != "#")
				begin
					code = $sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4);
					runStep(op, f1, f2, f3, f4);
				end
			end
			$fclose(fd);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/sramTrace.txt
# P|M client write address data (hex); a read's data is the value it must return
# A address: next pin address; L client address data: timed read; F client: full seen; D: drain
# Write then read, client 0 and client 1
P 0 1 00010 5a
P 0 0 00010 5a
D
P 1 1 4abcd c3
P 1 0 4abcd c3
D
# Reads come back in push order, 7ff00 never written
P 0 1 00100 11
P 0 1 00101 22
P 0 0 00101 22
P 0 0 00100 11
P 0 0 7ff00 f8
D
# Both clients loaded, grants alternate between ranges
A 4abcd
A 00100
A 4abce
A 00101
M 0 0 00100 11
P 1 0 4abcd c3
M 0 0 00101 22
P 1 0 4abce 61
D
# Client 0 fills while client 1 takes every other grant
M 0 0 00010 5a
P 1 0 4abcd c3
M 0 0 00100 11
P 1 0 4abce 61
M 0 0 00101 22
P 1 0 00010 5a
M 0 0 7ff00 f8
P 1 0 4abcd c3
M 0 0 00010 5a
P 1 0 4abce 61
M 0 0 00100 11
P 1 0 00100 11
P 0 0 00101 22
F 0
D
# Minimum latency with one client active
L 0 00010 5a
L 1 4abcd c3
D

// File: project.f
hdl/sramPkg.sv
hdl/sramCmdFifo.sv
hdl/sramArbiter.sv
hdl/sramPortUnit.sv
hdl/sramSubsystemTop.sv
verification/sramModel.sv
verification/sramTb.sv

// File: Bender.yml
package:
  name: sram_ctrl

sources:
  - hdl/sramPkg.sv
  - hdl/sramCmdFifo.sv
  - hdl/sramArbiter.sv
  - hdl/sramPortUnit.sv
  - hdl/sramSubsystemTop.sv
  - target: simulation
    files:
      - verification/sramModel.sv
      - verification/sramTb.sv
